/* compile.f */
rtl/w5500_regs_pkg.sv
rtl/w5500_ctrl_pkg.sv
rtl/spi_frame_if.sv
rtl/w5500_init_table.sv
rtl/w5500_spi_engine.sv
rtl/w5500_sequencer.sv
rtl/w5500_udp_tx.sv
dv/w5500_spi_model.sv
dv/tb_w5500_udp_tx.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_w5500_udp_tx
FILELIST  = compile.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -F -x '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/tb_w5500_udp_tx.sv */
`timescale 1ns/1ps

module tb_w5500_udp_tx;
    import w5500_regs_pkg::*;

    localparam int          PAYLOAD_BITS = 64;
    localparam logic [47:0] MAC_ADDR     = 48'h021A_2B3C_4D5E;
    localparam logic [31:0] LOCAL_IP     = 32'h0A00_0017;
    localparam logic [31:0] GATEWAY_IP   = 32'h0A00_0001;
    localparam logic [31:0] SUBNET_MASK  = 32'hFFFF_F000;
    localparam logic [15:0] SRC_PORT     = 16'h1F90;
    localparam logic [31:0] DST_IP       = 32'h0A00_0042;
    localparam logic [15:0] DST_PORT     = 16'h3039;

    localparam int     PTR_STEP     = PAYLOAD_BITS / 8;
    localparam int     FRAME_CYCLES = 2 * (24 + PAYLOAD_BITS) + 4;
    localparam int     TRANSFERS    = 13;
    localparam longint WATCHDOG_NS  = 2 * (31 + 3 + 4 * TRANSFERS) * FRAME_CYCLES * 8;

    logic                    clk;
    logic                    arst_n;
    logic                    spi_miso;
    logic                    spi_mosi;
    logic                    spi_sck;
    logic                    spi_cs_n;
    logic [PAYLOAD_BITS-1:0] tx_data;
    logic                    tx_valid;
    logic                    tx_ready;
    logic                    link_up;
    int                      frame_count;

    int          error_count;
    int          check_count;
    logic [15:0] lfsr;
    logic [15:0] exp_ptr;
    logic [15:0] exp_addr [$];
    logic [4:0]  exp_bsb  [$];
    logic [7:0]  exp_data [$];

    w5500_udp_tx #(
        .PAYLOAD_BITS (PAYLOAD_BITS),
        .MAC_ADDR     (MAC_ADDR),
        .LOCAL_IP     (LOCAL_IP),
        .GATEWAY_IP   (GATEWAY_IP),
        .SUBNET_MASK  (SUBNET_MASK),
        .SRC_PORT     (SRC_PORT),
        .DST_IP       (DST_IP),
        .DST_PORT     (DST_PORT)
    ) w5500_udp_tx_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .spi_miso (spi_miso),
        .spi_mosi (spi_mosi),
        .spi_sck  (spi_sck),
        .spi_cs_n (spi_cs_n),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .link_up  (link_up)
    );

    w5500_spi_model #(
        .PAYLOAD_BITS (PAYLOAD_BITS)
    ) w5500_spi_model_inst (
        .spi_sck     (spi_sck),
        .spi_cs_n    (spi_cs_n),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .frame_count (frame_count)
    );

    always #4 clk = ~clk;

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t %s got %04h expected %04h", $time, name, got, exp);
        end
    endtask

    task automatic check_ctrl(input string name, input w5500_ctrl_t got, input w5500_ctrl_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_payload(input string name, input logic [PAYLOAD_BITS-1:0] got,
                                 input logic [PAYLOAD_BITS-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic random_payload(output logic [PAYLOAD_BITS-1:0] word);
        for (int i = 0; i < PAYLOAD_BITS; i++) begin
            lfsr = lfsr_next(lfsr);
            word[i] = lfsr[0];
        end
    endtask

    task automatic wait_tx_ready(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (tx_ready !== level && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (tx_ready !== level) begin
            report_error($sformatf("tx_ready did not reach %0b within %0d cycles",
                                   level, max_cycles));
        end
    endtask

    task automatic wait_link_up(input int max_cycles);
        int n;
        n = 0;
        while (link_up !== 1'b1 && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (link_up !== 1'b1) begin
            report_error($sformatf("link_up did not rise within %0d cycles", max_cycles));
        end
    endtask

    task automatic check_frame(input int idx, input logic [15:0] addr, input logic [4:0] bsb,
                               input logic rwb, input int nbits);
        w5500_ctrl_t ctrl;
        ctrl.bsb = bsb;
        ctrl.rwb = rwb;
        ctrl.om  = 2'b00;
        check_word($sformatf("frame %0d address", idx), w5500_spi_model_inst.addr_log[idx], addr);
        check_ctrl($sformatf("frame %0d control", idx), w5500_spi_model_inst.ctrl_log[idx], ctrl);
        check_word($sformatf("frame %0d length", idx),
                   16'(w5500_spi_model_inst.nbits_log[idx]), 16'(nbits));
    endtask

    task automatic check_cmd_frame(input int idx, input logic [15:0] addr, input logic [4:0] bsb,
                                   input logic rwb, input logic [7:0] data);
        check_frame(idx, addr, bsb, rwb, 32);
        check_byte($sformatf("frame %0d data", idx), w5500_spi_model_inst.data_log[idx][7:0], data);
    endtask

    task automatic add_expect(input logic [15:0] addr, input logic [4:0] bsb,
                              input logic [7:0] data);
        exp_addr.push_back(addr);
        exp_bsb.push_back(bsb);
        exp_data.push_back(data);
    endtask

    // Bring-up writes in chip order with multi-byte values MSB first
    task automatic build_init_expect();
        add_expect(16'h002E, 5'd0, 8'hD8);
        for (int k = 0; k < 6; k++) begin
            add_expect(16'h0009 + 16'(k), 5'd0, MAC_ADDR[47 - 8*k -: 8]);
        end
        for (int k = 0; k < 4; k++) begin
            add_expect(16'h000F + 16'(k), 5'd0, LOCAL_IP[31 - 8*k -: 8]);
        end
        for (int k = 0; k < 4; k++) begin
            add_expect(16'h0001 + 16'(k), 5'd0, GATEWAY_IP[31 - 8*k -: 8]);
        end
        for (int k = 0; k < 4; k++) begin
            add_expect(16'h0005 + 16'(k), 5'd0, SUBNET_MASK[31 - 8*k -: 8]);
        end
        add_expect(16'h0000, 5'd1, 8'h02);
        add_expect(16'h001E, 5'd1, 8'd16);
        add_expect(16'h001F, 5'd1, 8'd16);
        for (int k = 0; k < 2; k++) begin
            add_expect(16'h0004 + 16'(k), 5'd1, SRC_PORT[15 - 8*k -: 8]);
        end
        add_expect(16'h0001, 5'd1, 8'h01);
        for (int k = 0; k < 4; k++) begin
            add_expect(16'h000C + 16'(k), 5'd1, DST_IP[31 - 8*k -: 8]);
        end
        for (int k = 0; k < 2; k++) begin
            add_expect(16'h0010 + 16'(k), 5'd1, DST_PORT[15 - 8*k -: 8]);
        end
    endtask

    // Pushes one word, optionally with a stray tx_valid while busy, and checks its four frames
    task automatic send_word(input logic [PAYLOAD_BITS-1:0] word, input bit poke);
        int          first;
        logic [15:0] next_ptr;
        wait_tx_ready(1'b1, FRAME_CYCLES * 4);
        first    = frame_count;
        tx_data  = word;
        tx_valid = 1'b1;
        @(posedge clk);
        #1;
        tx_valid = 1'b0;
        tx_data  = '0;
        check_bit("tx_ready after accept", tx_ready, 1'b0);
        if (poke) begin
            repeat (3) @(posedge clk);
            #1;
            tx_data  = ~word;
            tx_valid = 1'b1;
            @(posedge clk);
            #1;
            tx_valid = 1'b0;
            tx_data  = '0;
        end
        wait_tx_ready(1'b1, FRAME_CYCLES * 4 + 8);
        next_ptr = exp_ptr + 16'(PTR_STEP);
        if (frame_count != first + 4) begin
            report_error($sformatf("transfer gave %0d frames instead of 4", frame_count - first));
        end else begin
            check_frame(first, exp_ptr, 5'd2, 1'b1, 24 + PAYLOAD_BITS);
            check_payload($sformatf("frame %0d payload", first),
                          w5500_spi_model_inst.data_log[first], word);
            check_cmd_frame(first + 1, 16'h0025, 5'd1, 1'b1, next_ptr[7:0]);
            check_cmd_frame(first + 2, 16'h0024, 5'd1, 1'b1, next_ptr[15:8]);
            check_cmd_frame(first + 3, 16'h0001, 5'd1, 1'b1, 8'h20);
        end
        exp_ptr = next_ptr;
    endtask

    task automatic test_reset();
        repeat (5) @(posedge clk);
        #1;
        check_bit("spi_cs_n in reset", spi_cs_n, 1'b1);
        check_bit("spi_sck in reset", spi_sck, 1'b0);
        check_bit("tx_ready in reset", tx_ready, 1'b0);
        check_bit("link_up in reset", link_up, 1'b0);
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        #1;
        check_bit("spi_cs_n after reset", spi_cs_n, 1'b1);
        check_bit("spi_sck after reset", spi_sck, 1'b0);
        check_bit("tx_ready after reset", tx_ready, 1'b0);
        check_bit("link_up after reset", link_up, 1'b0);
    endtask

    task automatic test_bringup();
        wait_link_up(FRAME_CYCLES * 40);
        check_word("bring-up frame count", 16'(frame_count), 16'd34);
        build_init_expect();
        for (int k = 0; k < 31; k++) begin
            check_cmd_frame(k, exp_addr[k], exp_bsb[k], 1'b1, exp_data[k]);
        end
        // Model answers the third status read with the UDP code
        for (int k = 31; k < 34; k++) begin
            check_cmd_frame(k, 16'h0003, 5'd1, 1'b0, 8'h00);
        end
        check_bit("tx_ready", tx_ready, 1'b1);
    endtask

    task automatic test_single_transfer();
        logic [PAYLOAD_BITS-1:0] word;
        random_payload(word);
        send_word(word, 1'b0);
    endtask

    task automatic test_pointer_advance();
        logic [PAYLOAD_BITS-1:0] word;
        for (int n = 0; n < 10; n++) begin
            random_payload(word);
            send_word(word, 1'b0);
        end
    endtask

    task automatic test_back_pressure();
        logic [PAYLOAD_BITS-1:0] word;
        int                      first;
        random_payload(word);
        send_word(word, 1'b1);
        first = frame_count;
        repeat (FRAME_CYCLES) @(posedge clk);
        #1;
        check_word("frames after stray tx_valid", 16'(frame_count - first), 16'd0);
        check_bit("tx_ready while idle", tx_ready, 1'b1);
        // Pointer must continue from where the real transfer left it
        random_payload(word);
        send_word(word, 1'b0);
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        tx_data     = '0;
        tx_valid    = 1'b0;
        lfsr        = 16'd79;
        exp_ptr     = '0;
        error_count = 0;
        check_count = 0;
        test_reset();
        test_bringup();
        test_single_transfer();
        test_pointer_advance();
        test_back_pressure();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* dv/w5500_spi_model.sv */
`timescale 1ns/1ps

module w5500_spi_model #(
    parameter int PAYLOAD_BITS = 64,
    parameter int LOG_DEPTH    = 128
) (
    input  logic spi_sck,
    input  logic spi_cs_n,
    input  logic spi_mosi,
    output logic spi_miso,
    output int   frame_count
);
    import w5500_regs_pkg::*;

    localparam int MAX_BITS = 24 + PAYLOAD_BITS;

    // One entry per chip select window
    logic [15:0]             addr_log   [LOG_DEPTH];
    w5500_ctrl_t             ctrl_log   [LOG_DEPTH];
    logic [PAYLOAD_BITS-1:0] data_log   [LOG_DEPTH];
    int                      nbits_log  [LOG_DEPTH];

    logic [MAX_BITS-1:0] shift_in;
    logic [MAX_BITS-1:0] data_mask;
    int                  nbits;
    int                  poll_count;
    logic [7:0]          reply;

    initial begin
        spi_miso = 1'b0;
        shift_in = '0;
        reply    = 8'h00;
    end

    // Mode 0, MOSI taken on the rising sck edge
    always @(posedge spi_sck or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            if (nbits >= 32 && frame_count < LOG_DEPTH) begin
                data_mask = {MAX_BITS{1'b1}} >> (MAX_BITS - (nbits - 24));
                addr_log[frame_count]  = 16'(shift_in >> (nbits - 16));
                ctrl_log[frame_count]  = 8'(shift_in >> (nbits - 24));
                data_log[frame_count]  = PAYLOAD_BITS'(shift_in & data_mask);
                nbits_log[frame_count] = nbits;
                frame_count = frame_count + 1;
            end
            shift_in = '0;
            nbits    = 0;
        end else begin
            shift_in = {shift_in[MAX_BITS-2:0], spi_mosi};
            nbits    = nbits + 1;
        end
    end

    // Next MISO bit goes out on the falling edge, status reply in the data phase
    always @(negedge spi_sck or negedge spi_cs_n) begin
        if (nbits == 24) begin
            if (shift_in[23:8] == SN_SR && shift_in[7:3] == BSB_S0_REG && shift_in[2] == RWB_READ) begin
                reply = (poll_count < 2) ? 8'h00 : STATUS_UDP;
                poll_count = poll_count + 1;
            end else begin
                reply = 8'h00;
            end
        end
        if (nbits >= 24 && nbits < 32) begin
            spi_miso <= reply[31 - nbits];
        end else begin
            spi_miso <= 1'b0;
        end
    end

endmodule

/* rtl/w5500_udp_tx.sv */
`timescale 1ns/1ps

module w5500_udp_tx #(
    parameter int          PAYLOAD_BITS = 64,
    parameter logic [47:0] MAC_ADDR     = 48'hAAAF_FACC_E31C,
    parameter logic [31:0] LOCAL_IP     = 32'hC0A8_0AC1,
    parameter logic [31:0] GATEWAY_IP   = 32'hC0A8_0A01,
    parameter logic [31:0] SUBNET_MASK  = 32'hFFFF_FF00,
    parameter logic [15:0] SRC_PORT     = 16'd2390,
    parameter logic [31:0] DST_IP       = 32'hC0A8_0A02,
    parameter logic [15:0] DST_PORT     = 16'd5000
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    spi_miso,
    output logic                    spi_mosi,
    output logic                    spi_sck,
    output logic                    spi_cs_n,
    input  logic [PAYLOAD_BITS-1:0] tx_data,
    input  logic                    tx_valid,
    output logic                    tx_ready,
    output logic                    link_up
);
    import w5500_regs_pkg::*;
    import w5500_ctrl_pkg::*;

    step_t      step;
    w5500_cmd_t init_cmd;

    spi_frame_if #(.PAYLOAD_BITS(PAYLOAD_BITS)) frame_if ();

    w5500_sequencer #(
        .PAYLOAD_BITS(PAYLOAD_BITS)
    ) w5500_sequencer_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .init_cmd (init_cmd),
        .step     (step),
        .tx_ready (tx_ready),
        .link_up  (link_up),
        .frame    (frame_if.master)
    );

    w5500_init_table #(
        .MAC_ADDR    (MAC_ADDR),
        .LOCAL_IP    (LOCAL_IP),
        .GATEWAY_IP  (GATEWAY_IP),
        .SUBNET_MASK (SUBNET_MASK),
        .SRC_PORT    (SRC_PORT),
        .DST_IP      (DST_IP),
        .DST_PORT    (DST_PORT)
    ) w5500_init_table_inst (
        .step (step),
        .cmd  (init_cmd)
    );

    w5500_spi_engine #(
        .PAYLOAD_BITS(PAYLOAD_BITS)
    ) w5500_spi_engine_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .spi_miso (spi_miso),
        .spi_mosi (spi_mosi),
        .spi_sck  (spi_sck),
        .spi_cs_n (spi_cs_n),
        .frame    (frame_if.engine)
    );

endmodule

/* rtl/w5500_sequencer.sv */
`timescale 1ns/1ps

module w5500_sequencer #(
    parameter int PAYLOAD_BITS = 64
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [PAYLOAD_BITS-1:0]    tx_data,
    input  logic                       tx_valid,
    input  w5500_regs_pkg::w5500_cmd_t init_cmd,
    output w5500_ctrl_pkg::step_t      step,
    output logic                       tx_ready,
    output logic                       link_up,
    spi_frame_if.master                frame
);
    import w5500_regs_pkg::*;
    import w5500_ctrl_pkg::*;

    localparam logic [15:0] PTR_STEP = 16'(PAYLOAD_BITS / 8);

    seq_state_t              state;
    logic                    issued;
    logic [15:0]             tx_wr;
    logic [PAYLOAD_BITS-1:0] data_q;

    // Each state visit launches one frame once the engine is idle
    assign frame.start      = (state != ST_IDLE) && !issued && !frame.busy;
    assign frame.is_payload = (state == ST_TX_DATA);
    assign frame.payload    = data_q;

    assign tx_ready = (state == ST_IDLE);
    assign link_up  = (state != ST_INIT) && (state != ST_POLL);

    always_comb begin
        case (state)
            ST_POLL:     frame.cmd = w5500_cmd(SN_SR, BSB_S0_REG, RWB_READ, 8'h00);
            // Address field carries the TX buffer pointer
            ST_TX_DATA:  frame.cmd = w5500_cmd(tx_wr, BSB_S0_TX, RWB_WRITE, 8'h00);
            ST_TX_WR_LO: frame.cmd = w5500_cmd(SN_TX_WR1, BSB_S0_REG, RWB_WRITE, tx_wr[7:0]);
            ST_TX_WR_HI: frame.cmd = w5500_cmd(SN_TX_WR0, BSB_S0_REG, RWB_WRITE, tx_wr[15:8]);
            ST_TX_SEND:  frame.cmd = w5500_cmd(SN_CR, BSB_S0_REG, RWB_WRITE, CMD_SEND);
            default:     frame.cmd = init_cmd;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ST_INIT;
            issued <= 1'b0;
            step   <= '0;
            tx_wr  <= '0;
        end else begin
            if (frame.start) begin
                issued <= 1'b1;
            end
            if (frame.done) begin
                issued <= 1'b0;
            end
            case (state)
                ST_INIT: begin
                    if (frame.done) begin
                        if (step == step_t'(INIT_STEPS - 1)) begin
                            state <= ST_POLL;
                        end else begin
                            step <= step + 1'b1;
                        end
                    end
                end
                // Keep reading status until the socket reports UDP
                ST_POLL: begin
                    if (frame.done && frame.rx_byte == STATUS_UDP) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (tx_valid) begin
                        state <= ST_TX_DATA;
                    end
                end
                ST_TX_DATA: begin
                    if (frame.done) begin
                        tx_wr <= tx_wr + PTR_STEP;
                        state <= ST_TX_WR_LO;
                    end
                end
                ST_TX_WR_LO: begin
                    if (frame.done) begin
                        state <= ST_TX_WR_HI;
                    end
                end
                ST_TX_WR_HI: begin
                    if (frame.done) begin
                        state <= ST_TX_SEND;
                    end
                end
                ST_TX_SEND: begin
                    if (frame.done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_INIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && tx_valid) begin
            data_q <= tx_data;
        end
    end

endmodule

/* rtl/w5500_spi_engine.sv */
`timescale 1ns/1ps

module w5500_spi_engine #(
    parameter int PAYLOAD_BITS = 64
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        spi_miso,
    output logic        spi_mosi,
    output logic        spi_sck,
    output logic        spi_cs_n,
    spi_frame_if.engine frame
);
    import w5500_ctrl_pkg::*;

    localparam int SR_BITS = HDR_BITS + PAYLOAD_BITS;
    localparam int CNT_W   = $clog2(2 * SR_BITS + 1);

    logic [SR_BITS-1:0] sreg;
    logic [CNT_W-1:0]   half_cnt;
    logic [CNT_W-1:0]   half_end;
    logic [7:0]         rx_shift;
    logic               busy;
    logic               done;

    assign frame.busy    = busy;
    assign frame.done    = done;
    assign frame.rx_byte = rx_shift;

    // Two clk cycles per bit, frame closes one idle half bit after the last fall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            spi_cs_n <= 1'b1;
            spi_sck  <= 1'b0;
            spi_mosi <= 1'b0;
            half_cnt <= '0;
            half_end <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (frame.start) begin
                    busy     <= 1'b1;
                    spi_cs_n <= 1'b0;
                    half_cnt <= '0;
                    spi_mosi <= frame.cmd.raw[CMD_BITS-1];
                    if (frame.is_payload) begin
                        half_end <= CNT_W'(2 * SR_BITS);
                    end else begin
                        half_end <= CNT_W'(2 * CMD_BITS);
                    end
                end
            end else if (half_cnt == half_end) begin
                busy     <= 1'b0;
                done     <= 1'b1;
                spi_cs_n <= 1'b1;
                spi_mosi <= 1'b0;
            end else begin
                half_cnt <= half_cnt + 1'b1;
                spi_sck  <= ~spi_sck;
                // Next bit goes out while sck falls
                if (spi_sck) begin
                    spi_mosi <= sreg[SR_BITS-2];
                end
            end
        end
    end

    // Command sits left-aligned, payload frame is header plus data
    always_ff @(posedge clk) begin
        if (!busy && frame.start) begin
            if (frame.is_payload) begin
                sreg <= {frame.cmd.raw[CMD_BITS-1 -: HDR_BITS], frame.payload};
            end else begin
                sreg <= SR_BITS'(frame.cmd.raw) << (SR_BITS - CMD_BITS);
            end
        end else if (busy && spi_sck) begin
            sreg <= {sreg[SR_BITS-2:0], 1'b0};
        end
        // MISO taken on each sck rise
        if (busy && !spi_sck && half_cnt != half_end) begin
            rx_shift <= {rx_shift[6:0], spi_miso};
        end
    end

endmodule

/* rtl/w5500_init_table.sv */
`timescale 1ns/1ps

module w5500_init_table #(
    parameter logic [47:0] MAC_ADDR    = 48'hAAAF_FACC_E31C,
    parameter logic [31:0] LOCAL_IP    = 32'hC0A8_0AC1,
    parameter logic [31:0] GATEWAY_IP  = 32'hC0A8_0A01,
    parameter logic [31:0] SUBNET_MASK = 32'hFFFF_FF00,
    parameter logic [15:0] SRC_PORT    = 16'd2390,
    parameter logic [31:0] DST_IP      = 32'hC0A8_0A02,
    parameter logic [15:0] DST_PORT    = 16'd5000
) (
    input  w5500_ctrl_pkg::step_t      step,
    output w5500_regs_pkg::w5500_cmd_t cmd
);
    import w5500_regs_pkg::*;

    logic [4:0]  offs;
    logic [15:0] base;
    logic [4:0]  bsb;
    logic [7:0]  data;

    // Multi-byte fields go out most significant byte first
    always_comb begin
        offs = '0;
        base = REG_PHYCFGR;
        bsb  = BSB_COMMON;
        data = PHY_MODE;
        case (step) inside
            [5'd1:5'd6]: begin
                offs = step - 5'd1;
                base = REG_SHAR0;
                data = MAC_ADDR[47 - 8*offs -: 8];
            end
            [5'd7:5'd10]: begin
                offs = step - 5'd7;
                base = REG_SIPR0;
                data = LOCAL_IP[31 - 8*offs -: 8];
            end
            [5'd11:5'd14]: begin
                offs = step - 5'd11;
                base = REG_GAR0;
                data = GATEWAY_IP[31 - 8*offs -: 8];
            end
            [5'd15:5'd18]: begin
                offs = step - 5'd15;
                base = REG_SUBR0;
                data = SUBNET_MASK[31 - 8*offs -: 8];
            end
            5'd19: begin
                bsb  = BSB_S0_REG;
                base = SN_MR;
                data = MODE_UDP;
            end
            5'd20, 5'd21: begin
                bsb  = BSB_S0_REG;
                base = (step == 5'd20) ? SN_RXBUF_SIZE : SN_TXBUF_SIZE;
                data = BUF_SIZE;
            end
            [5'd22:5'd23]: begin
                offs = step - 5'd22;
                bsb  = BSB_S0_REG;
                base = SN_PORT0;
                data = SRC_PORT[15 - 8*offs -: 8];
            end
            5'd24: begin
                bsb  = BSB_S0_REG;
                base = SN_CR;
                data = CMD_OPEN;
            end
            [5'd25:5'd28]: begin
                offs = step - 5'd25;
                bsb  = BSB_S0_REG;
                base = SN_DIPR0;
                data = DST_IP[31 - 8*offs -: 8];
            end
            [5'd29:5'd30]: begin
                offs = step - 5'd29;
                bsb  = BSB_S0_REG;
                base = SN_DPORT0;
                data = DST_PORT[15 - 8*offs -: 8];
            end
            default: ;
        endcase
        cmd = w5500_cmd(base + 16'(offs), bsb, RWB_WRITE, data);
    end

endmodule

/* rtl/spi_frame_if.sv */
`timescale 1ns/1ps

interface spi_frame_if #(
    parameter int PAYLOAD_BITS = 64
);
    import w5500_regs_pkg::*;

    logic                    start;
    logic                    is_payload;
    w5500_cmd_t              cmd;
    logic [PAYLOAD_BITS-1:0] payload;

    logic                    busy;
    logic                    done;
    logic [7:0]              rx_byte;

    modport master (
        output start,
        output is_payload,
        output cmd,
        output payload,
        input  busy,
        input  done,
        input  rx_byte
    );

    modport engine (
        input  start,
        input  is_payload,
        input  cmd,
        input  payload,
        output busy,
        output done,
        output rx_byte
    );

endinterface

/* rtl/w5500_ctrl_pkg.sv */
package w5500_ctrl_pkg;

    // Address, control and one data byte
    localparam int CMD_BITS = 32;
    // Address and control ahead of a TX buffer burst
    localparam int HDR_BITS = 24;

    localparam int INIT_STEPS = 31;

    typedef logic [4:0] step_t;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_POLL,
        ST_IDLE,
        ST_TX_DATA,
        ST_TX_WR_LO,
        ST_TX_WR_HI,
        ST_TX_SEND
    } seq_state_t;

endpackage

/* rtl/w5500_regs_pkg.sv */
package w5500_regs_pkg;

    // SPI control phase: block select, read/write, operating mode
    typedef struct packed {
        logic [4:0] bsb;
        logic       rwb;
        logic [1:0] om;
    } w5500_ctrl_t;

    typedef struct packed {
        logic [15:0] addr;
        w5500_ctrl_t ctrl;
        logic [7:0]  data;
    } w5500_fields_t;

    // Same command word seen as fields or as the raw MSB-first frame
    typedef union packed {
        w5500_fields_t f;
        logic [31:0]   raw;
    } w5500_cmd_t;

    localparam logic [4:0] BSB_COMMON = 5'b00000;
    localparam logic [4:0] BSB_S0_REG = 5'b00001;
    localparam logic [4:0] BSB_S0_TX  = 5'b00010;
    localparam logic       RWB_READ   = 1'b0;
    localparam logic       RWB_WRITE  = 1'b1;
    // Variable data length mode, frame ends on chip select
    localparam logic [1:0] OM_VDM     = 2'b00;

    // Common register block
    localparam logic [15:0] REG_GAR0    = 16'h0001;
    localparam logic [15:0] REG_SUBR0   = 16'h0005;
    localparam logic [15:0] REG_SHAR0   = 16'h0009;
    localparam logic [15:0] REG_SIPR0   = 16'h000F;
    localparam logic [15:0] REG_PHYCFGR = 16'h002E;

    // Socket 0 register block
    localparam logic [15:0] SN_MR         = 16'h0000;
    localparam logic [15:0] SN_CR         = 16'h0001;
    localparam logic [15:0] SN_SR         = 16'h0003;
    localparam logic [15:0] SN_PORT0      = 16'h0004;
    localparam logic [15:0] SN_DIPR0      = 16'h000C;
    localparam logic [15:0] SN_DPORT0     = 16'h0010;
    localparam logic [15:0] SN_RXBUF_SIZE = 16'h001E;
    localparam logic [15:0] SN_TXBUF_SIZE = 16'h001F;
    localparam logic [15:0] SN_TX_WR0     = 16'h0024;
    localparam logic [15:0] SN_TX_WR1     = 16'h0025;

    localparam logic [7:0] PHY_MODE   = 8'hD8;
    localparam logic [7:0] MODE_UDP   = 8'h02;
    localparam logic [7:0] BUF_SIZE   = 8'd16;
    localparam logic [7:0] CMD_OPEN   = 8'h01;
    localparam logic [7:0] CMD_SEND   = 8'h20;
    localparam logic [7:0] STATUS_UDP = 8'h22;

    function automatic w5500_cmd_t w5500_cmd(
        input logic [15:0] addr,
        input logic [4:0]  bsb,
        input logic        rwb,
        input logic [7:0]  data
    );
        w5500_cmd_t c;
        c.f.addr     = addr;
        c.f.ctrl.bsb = bsb;
        c.f.ctrl.rwb = rwb;
        c.f.ctrl.om  = OM_VDM;
        c.f.data     = data;
        return c;
    endfunction

endpackage
